// File: control.sv
`timescale 1ns/1ps
`default_nettype none

module control
    import mips_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic r_valid,
    input  logic retire_credit,
    input  logic queue_empty,
    output logic advance,
    output logic pop,
    output logic retire_fire
);
    logic [CREDIT_W-1:0] credit_cnt;
    logic                has_credit;

    assign has_credit  = (credit_cnt != '0);
    assign retire_fire = r_valid && has_credit;

    // a full retire stage with no credit freezes every stage
    assign advance = !r_valid || has_credit;
    assign pop     = advance && !queue_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({retire_credit, retire_fire})
                2'b10: begin
                    // saturates at the top of the counter
                    if (credit_cnt != '1) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import mips_pkg::*;
#(
    parameter int FETCH_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     in_instr,
    input  logic      retire_credit,
    output logic      in_credit,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_wen,
    output reg_addr_t retire_addr,
    output word_t     retire_data
);
    logic         queue_empty;
    word_t        head_instr;
    word_t        head_pc;
    logic         pop;
    logic         advance;
    logic         retire_fire;
    reg_addr_t    rd_addr_a;
    reg_addr_t    rd_addr_b;
    word_t        rd_data_a;
    word_t        rd_data_b;
    decode_data_t dec;
    logic         e_valid;
    decode_data_t e_data;
    exec_data_t   x_data;
    logic         r_valid;
    exec_data_t   r_data;
    logic         rf_wen;

    fetch_queue #(
        .FETCH_DEPTH (FETCH_DEPTH),
        .RESET_PC    (RESET_PC)
    ) fetch_queue_inst (
        .clk, .rst_n, .in_valid, .in_instr, .pop, .in_credit,
        .empty (queue_empty),
        .head_instr, .head_pc
    );

    decode decode_inst (
        .head_instr, .head_pc, .rd_data_a, .rd_data_b,
        .rd_addr_a, .rd_addr_b, .dec
    );

    // head of the queue into execute
    pipe_reg #(.payload_t(decode_data_t)) e_reg (
        .clk, .rst_n, .advance,
        .in_valid  (pop),
        .in_data   (dec),
        .out_valid (e_valid),
        .out_data  (e_data)
    );

    execute execute_inst (
        .e_valid, .e_data, .r_valid, .r_data, .x_data
    );

    pipe_reg #(.payload_t(exec_data_t)) r_reg (
        .clk, .rst_n, .advance,
        .in_valid  (e_valid),
        .in_data   (x_data),
        .out_valid (r_valid),
        .out_data  (r_data)
    );

    // write only when the record actually leaves
    assign rf_wen = retire_fire && r_data.wen;

    regfile regfile_inst (
        .clk, .rst_n, .rd_addr_a, .rd_addr_b,
        .wen     (rf_wen),
        .wr_addr (r_data.dest),
        .wr_data (r_data.result),
        .rd_data_a, .rd_data_b
    );

    control control_inst (
        .clk, .rst_n, .r_valid, .retire_credit, .queue_empty,
        .advance, .pop, .retire_fire
    );

    assign retire_valid = retire_fire;
    assign retire_pc    = r_data.pc;
    assign retire_wen   = r_data.wen;
    assign retire_addr  = r_data.dest;
    assign retire_data  = r_data.result;

endmodule

`default_nettype wire

// File: datapath_assert.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_assert (
    input logic clk,
    input logic rst_n,
    input logic r_valid,
    input logic queue_empty,
    input logic retire_credit,
    input logic advance,
    input logic pop,
    input logic retire_fire
);
    // retire credits seen on the port, kept apart from the control counter
    int credits_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_seen <= 0;
        end else begin
            case ({retire_credit, retire_fire})
                2'b10:   credits_seen <= credits_seen + 1;
                2'b01:   credits_seen <= credits_seen - 1;
                default: credits_seen <= credits_seen;
            endcase
        end
    end

    // stall only with a full retire stage and no credit
    stall_needs_no_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !advance |-> (r_valid && (credits_seen == 0))
    ) else $error("advance low while the retire stage could leave");

    fire_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_fire |-> (credits_seen > 0)
    ) else $error("retire_fire with no retire credit granted");

    // a pop needs an entry and a pipeline that is free to move
    pop_needs_entry: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (!queue_empty && !(r_valid && (credits_seen == 0)))
    ) else $error("pop from an empty fetch queue or a stalled pipeline");

endmodule

bind control datapath_assert datapath_assert_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .r_valid       (r_valid),
    .queue_empty   (queue_empty),
    .retire_credit (retire_credit),
    .advance       (advance),
    .pop           (pop),
    .retire_fire   (retire_fire)
);

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode
    import mips_pkg::*;
(
    input  word_t        head_instr,
    input  word_t        head_pc,
    input  word_t        rd_data_a,
    input  word_t        rd_data_b,
    output reg_addr_t    rd_addr_a,
    output reg_addr_t    rd_addr_b,
    output decode_data_t dec
);
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;

    assign opcode   = head_instr[31:26];
    assign rs       = head_instr[25:21];
    assign rt       = head_instr[20:16];
    assign rd       = head_instr[15:11];
    assign funct    = head_instr[5:0];
    assign imm_sext = {{16{head_instr[15]}}, head_instr[15:0]};
    assign imm_zext = {16'b0, head_instr[15:0]};

    assign rd_addr_a = rs;
    assign rd_addr_b = rt;

    always_comb begin
        dec         = '0;
        dec.pc      = head_pc;
        dec.rs      = rs;
        dec.rt      = rt;
        dec.rs_val  = rd_data_a;
        dec.rt_val  = rd_data_b;
        dec.shamt   = head_instr[10:6];
        // i-type defaults: rt is the target, zero-extended immediate
        dec.use_imm = 1'b1;
        dec.imm     = imm_zext;
        dec.dest    = rt;
        dec.alu_op  = ALU_NONE;
        case (opcode)
            OP_SPECIAL: begin
                dec.use_imm = 1'b0;
                dec.dest    = rd;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_NOR:  dec.alu_op = ALU_NOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    default: dec.alu_op = ALU_NONE;
                endcase
            end
            OP_ADDIU: begin
                dec.alu_op = ALU_ADD;
                dec.imm    = imm_sext;
            end
            OP_SLTI: begin
                dec.alu_op = ALU_SLT;
                dec.imm    = imm_sext;
            end
            OP_ANDI: dec.alu_op = ALU_AND;
            OP_ORI:  dec.alu_op = ALU_OR;
            OP_XORI: dec.alu_op = ALU_XOR;
            OP_LUI:  dec.alu_op = ALU_LUI;
            default: dec.alu_op = ALU_NONE;
        endcase
        // unknown encodings and $zero targets retire without a write
        dec.wen = (dec.alu_op != ALU_NONE) && (dec.dest != '0);
    end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute
    import mips_pkg::*;
(
    input  logic         e_valid,
    input  decode_data_t e_data,
    input  logic         r_valid,
    input  exec_data_t   r_data,
    output exec_data_t   x_data
);
    logic  fwd_ok;
    word_t src_a;
    word_t src_b;
    word_t op_b;
    word_t result;

    // retire stage result counts only if it will land in the regfile
    assign fwd_ok = r_valid && r_data.wen && (r_data.dest != '0);

    assign src_a = (fwd_ok && (r_data.dest == e_data.rs)) ? r_data.result : e_data.rs_val;
    assign src_b = (fwd_ok && (r_data.dest == e_data.rt)) ? r_data.result : e_data.rt_val;
    assign op_b  = e_data.use_imm ? e_data.imm : src_b;

    always_comb begin
        case (e_data.alu_op)
            ALU_ADD: result = src_a + op_b;
            ALU_SUB: result = src_a - op_b;
            ALU_AND: result = src_a & op_b;
            ALU_OR:  result = src_a | op_b;
            ALU_XOR: result = src_a ^ op_b;
            ALU_NOR: result = ~(src_a | op_b);
            // signed compare, covers slt and slti
            ALU_SLT: result = {31'b0, $signed(src_a) < $signed(op_b)};
            // shifts take rt, never the immediate
            ALU_SLL: result = src_b << e_data.shamt;
            ALU_SRL: result = src_b >> e_data.shamt;
            ALU_LUI: result = {e_data.imm[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    always_comb begin
        x_data.pc     = e_data.pc;
        x_data.wen    = e_valid && e_data.wen;
        x_data.dest   = e_data.dest;
        x_data.result = result;
    end

endmodule

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import mips_pkg::*;
#(
    parameter int    FETCH_DEPTH = 4,
    parameter word_t RESET_PC    = mips_pkg::RESET_PC
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  word_t in_instr,
    input  logic  pop,
    output logic  in_credit,
    output logic  empty,
    output word_t head_instr,
    output word_t head_pc
);
    localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FETCH_DEPTH - 1);

    word_t instr_mem [FETCH_DEPTH];
    word_t pc_mem [FETCH_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0] count;
    word_t next_pc;

    assign empty      = (count == '0);
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    // entries carry the pc they were fetched at
    always_ff @(posedge clk) begin
        if (in_valid) begin
            instr_mem[wr_ptr] <= in_instr;
            pc_mem[wr_ptr]    <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            next_pc   <= RESET_PC;
            in_credit <= 1'b0;
        end else begin
            // one credit back to the source per freed entry
            in_credit <= pop;
            if (in_valid) begin
                wr_ptr  <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
                next_pc <= next_pc + 32'd4;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // pc of the first fetched word
    localparam word_t RESET_PC = 32'hbfc0_0000;

    // width of the credit counters on both streams
    localparam int CREDIT_W = 4;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field, only meaningful under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_NONE
    } alu_op_t;

    // decode to execute
    typedef struct packed {
        word_t      pc;
        alu_op_t    alu_op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        word_t      rs_val;
        word_t      rt_val;
        logic       use_imm;
        word_t      imm;
        logic [4:0] shamt;
        reg_addr_t  dest;
        logic       wen;
    } decode_data_t;

    // execute to retire
    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t dest;
        word_t     result;
    } exec_data_t;

endpackage

`default_nettype wire

// File: pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // payload only matters while out_valid is set
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    input  logic      wen,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rd_data_a,
    output word_t     rd_data_b
);
    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wen && (rd_addr_a == wr_addr)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wen && (rd_addr_b == wr_addr)) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_datapath \
    -f src.f \
    -Mdir obj_dir

./obj_dir/Vtb_datapath

// File: src.f
mips_pkg.sv
fetch_queue.sv
decode.sv
pipe_reg.sv
execute.sv
regfile.sv
control.sv
datapath.sv
datapath_assert.sv
tb_datapath.sv

// File: tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_datapath
    import mips_pkg::*;
();
    localparam int FETCH_DEPTH      = 4;
    localparam int NUM_INSTR        = 400;
    localparam int TIMEOUT_CYCLES   = NUM_INSTR * 8;
    localparam int MAX_SINK_CREDITS = 8;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    word_t     in_instr;
    logic      retire_credit;
    logic      in_credit;
    logic      retire_valid;
    word_t     retire_pc;
    logic      retire_wen;
    reg_addr_t retire_addr;
    word_t     retire_data;

    int    seed;
    word_t program_mem [NUM_INSTR];
    word_t model_regs [32];
    int    issued;
    int    retired;
    int    src_credits;
    int    sink_credits;
    logic  credit_pending;
    int    cycle_count = 0;

    datapath #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) datapath_inst (
        .clk, .rst_n, .in_valid, .in_instr, .retire_credit,
        .in_credit, .retire_valid, .retire_pc, .retire_wen, .retire_addr, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at time %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic word_t r_type(input int rs, input int rt, input int rd, input int shamt,
                                     input logic [5:0] funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // registers 0..7 only, so neighbours often depend on each other
    function automatic word_t random_instr();
        int          sel;
        int          rs;
        int          rt;
        int          rd;
        int          shamt;
        logic [15:0] imm;
        word_t       instr;
        sel   = rand_below(16);
        rs    = rand_below(8);
        rt    = rand_below(8);
        rd    = rand_below(8);
        shamt = rand_below(32);
        imm   = 16'(rand_below(65536));
        case (sel)
            0:  instr = r_type(rs, rt, rd, 0, 6'h21);
            1:  instr = r_type(rs, rt, rd, 0, 6'h23);
            2:  instr = r_type(rs, rt, rd, 0, 6'h24);
            3:  instr = r_type(rs, rt, rd, 0, 6'h25);
            4:  instr = r_type(rs, rt, rd, 0, 6'h26);
            5:  instr = r_type(rs, rt, rd, 0, 6'h27);
            6:  instr = r_type(rs, rt, rd, 0, 6'h2a);
            7:  instr = r_type(0, rt, rd, shamt, 6'h00);
            8:  instr = r_type(0, rt, rd, shamt, 6'h02);
            9:  instr = i_type(6'h09, rs, rt, imm);
            10: instr = i_type(6'h0a, rs, rt, imm);
            11: instr = i_type(6'h0c, rs, rt, imm);
            12: instr = i_type(6'h0d, rs, rt, imm);
            13: instr = i_type(6'h0e, rs, rt, imm);
            14: instr = i_type(6'h0f, 0, rt, imm);
            // lw or a trapping add, neither is implemented
            default: instr = (imm[0]) ? i_type(6'h23, rs, rt, imm) : r_type(rs, rt, rd, 0, 6'h20);
        endcase
        return instr;
    endfunction

    // in-order reference, one instruction per call
    task automatic model_step(input word_t instr, output logic exp_wen,
                              output reg_addr_t exp_addr, output word_t exp_data);
        word_t a;
        word_t b;
        word_t sext;
        word_t zext;
        word_t res;
        logic  known;
        a     = model_regs[instr[25:21]];
        b     = model_regs[instr[20:16]];
        sext  = {{16{instr[15]}}, instr[15:0]};
        zext  = {16'h0, instr[15:0]};
        known = 1'b1;
        res   = '0;
        exp_addr = instr[20:16];
        case (instr[31:26])
            6'h00: begin
                exp_addr = instr[15:11];
                case (instr[5:0])
                    6'h21:   res = a + b;
                    6'h23:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h26:   res = a ^ b;
                    6'h27:   res = ~(a | b);
                    6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00:   res = b << instr[10:6];
                    6'h02:   res = b >> instr[10:6];
                    default: known = 1'b0;
                endcase
            end
            6'h09:   res = a + sext;
            6'h0a:   res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            6'h0c:   res = a & zext;
            6'h0d:   res = a | zext;
            6'h0e:   res = a ^ zext;
            6'h0f:   res = {instr[15:0], 16'h0};
            default: known = 1'b0;
        endcase
        exp_wen  = known && (exp_addr != 5'd0);
        exp_data = res;
        if (exp_wen) begin
            model_regs[exp_addr] = res;
        end
    endtask

    task automatic check_retire();
        logic      exp_wen;
        reg_addr_t exp_addr;
        word_t     exp_data;
        model_step(program_mem[retired], exp_wen, exp_addr, exp_data);
        check_value("retire_pc", retire_pc, RESET_PC + 32'(retired * 4));
        check_value("retire_wen", 32'(retire_wen), 32'(exp_wen));
        // address and data only mean something for a real write
        if (exp_wen) begin
            check_value("retire_addr", 32'(retire_addr), 32'(exp_addr));
            check_value("retire_data", retire_data, exp_data);
        end
    endtask

    task automatic drive_inputs();
        if (issued < NUM_INSTR && src_credits > 0 && rand_below(4) != 0) begin
            in_valid = 1'b1;
            in_instr = program_mem[issued];
            issued++;
            src_credits--;
        end else begin
            in_valid = 1'b0;
            in_instr = '0;
        end
        // sink keeps its grants below the DUT counter range
        credit_pending = (sink_credits < MAX_SINK_CREDITS) && (rand_below(2) == 0);
        retire_credit  = credit_pending;
    endtask

    task automatic sample_outputs();
        if (in_credit) begin
            src_credits++;
            if (src_credits > FETCH_DEPTH) begin
                report_failure("in_credit returned more credits than the source spent");
            end
        end
        if (retire_valid) begin
            if (sink_credits == 0) begin
                report_failure("retire_valid was high without a granted retire credit");
            end
            if (retired >= issued) begin
                report_failure("retire_valid was high with no instruction outstanding");
            end
            sink_credits--;
            check_retire();
            retired++;
        end
    endtask

    initial begin
        seed           = 32'h50bd_7304;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_instr       = '0;
        retire_credit  = 1'b0;
        issued         = 0;
        retired        = 0;
        src_credits    = FETCH_DEPTH;
        sink_credits   = 0;
        credit_pending = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            program_mem[i] = random_instr();
        end
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        while (retired < NUM_INSTR) begin
            @(posedge clk);
            // a grant counts once the DUT has registered it
            if (credit_pending) begin
                sink_credits++;
            end
            #10;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        // idle tail, a duplicate record would show up here
        repeat (8) begin
            @(posedge clk);
            if (credit_pending) begin
                sink_credits++;
            end
            #10;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        check_value("source credits", 32'(src_credits), 32'(FETCH_DEPTH));
        $display("TEST RESULT: PASS");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure("timeout: not every instruction retired within the cycle limit");
        end
    end

endmodule

`default_nettype wire
